// ==== hw/tcdm_defines.svh ====
// TCDM adapter widths and AMO opcode encodings shared by the whole design
`ifndef TCDM_DEFINES_SVH
`define TCDM_DEFINES_SVH

// ---------------------------------------------------------
// bus widths
// ---------------------------------------------------------
`define TCDM_ADDR_WIDTH 32
`define TCDM_DATA_WIDTH 32
`define TCDM_BE_WIDTH   4
`define TCDM_META_WIDTH 8
`define TCDM_AMO_WIDTH  4

// ---------------------------------------------------------
// AMO opcodes, LR/SC codes are not supported
// ---------------------------------------------------------
`define TCDM_AMO_NONE 4'h0
`define TCDM_AMO_SWAP 4'h1
`define TCDM_AMO_ADD  4'h2
`define TCDM_AMO_AND  4'h3
`define TCDM_AMO_OR   4'h4
`define TCDM_AMO_XOR  4'h5
`define TCDM_AMO_MAX  4'h6
`define TCDM_AMO_MAXU 4'h7
`define TCDM_AMO_MIN  4'h8
`define TCDM_AMO_MINU 4'h9

`endif

// ==== hw/tcdm_pkg.sv ====
// TCDM adapter types for addresses, data, byte enables, metadata and AMO control
`include "tcdm_defines.svh"

package tcdm_pkg;

  // ---------------------------------------------------------
  // payload vectors
  // ---------------------------------------------------------
  typedef logic [`TCDM_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`TCDM_DATA_WIDTH-1:0] data_t;
  typedef logic [`TCDM_BE_WIDTH-1:0]   be_t;

  // opaque requester tag, returned untouched with the response
  typedef logic [`TCDM_META_WIDTH-1:0] meta_t;

  // ---------------------------------------------------------
  // atomics
  // ---------------------------------------------------------
  typedef enum logic [`TCDM_AMO_WIDTH-1:0] {
    amo_none = `TCDM_AMO_NONE,
    amo_swap = `TCDM_AMO_SWAP,
    amo_add  = `TCDM_AMO_ADD,
    amo_and  = `TCDM_AMO_AND,
    amo_or   = `TCDM_AMO_OR,
    amo_xor  = `TCDM_AMO_XOR,
    amo_max  = `TCDM_AMO_MAX,
    amo_maxu = `TCDM_AMO_MAXU,
    amo_min  = `TCDM_AMO_MIN,
    amo_minu = `TCDM_AMO_MINU
  } amo_op_e;

  // idle until an AMO is loaded, then one commit cycle
  typedef enum logic {
    amo_idle   = 1'b0,
    amo_commit = 1'b1
  } amo_state_e;

endpackage

// ==== hw/resp_meta_if.sv ====
// Metadata handshake between the bank port and the response metadata store
`timescale 1ns/1ps

interface resp_meta_if;

  // push when a read or an AMO is accepted
  logic push;
  // store cannot take another outstanding read
  logic full;
  // oldest metadata entry present
  logic valid;
  // response handed to the requester
  logic pop;
  // metadata of the oldest outstanding read
  tcdm_pkg::meta_t meta;

  // storage side
  modport buffer (
    input  push,
    input  pop,
    output full,
    output valid,
    output meta
  );

  // bank port side
  modport port (
    output push,
    output pop,
    input  full,
    input  valid,
    input  meta
  );

endinterface

// ==== hw/tcdm_amo_unit.sv ====
// AMO unit capturing an accepted atomic and producing its read-modify-write commit
`timescale 1ns/1ps
`include "tcdm_defines.svh"

module tcdm_amo_unit (
  input  logic              clk_i,
  input  logic              rst_ni,
  // accepted AMO from the bank port
  input  logic              load_i,
  input  tcdm_pkg::amo_op_e op_i,
  input  tcdm_pkg::addr_t   addr_i,
  input  tcdm_pkg::data_t   operand_i,
  // old value, valid the cycle after the load
  input  tcdm_pkg::data_t   bank_rdata_i,
  // commit write back to the bank
  output logic              commit_o,
  output tcdm_pkg::addr_t   commit_addr_o,
  output tcdm_pkg::data_t   commit_wdata_o
);

  tcdm_pkg::amo_state_e state_q, state_d;

  // captured request
  tcdm_pkg::amo_op_e op_q;
  tcdm_pkg::addr_t   addr_q;
  tcdm_pkg::data_t   operand_q;

  // shared adder, one bit wider for the compare sign
  logic [`TCDM_DATA_WIDTH:0] adder_a;
  logic [`TCDM_DATA_WIDTH:0] adder_b;
  logic [`TCDM_DATA_WIDTH:0] adder_sum;
  logic                      adder_cin;
  logic                      is_signed;
  logic                      is_cmp;
  logic                      is_less;

  // ---------------------------------------------------------
  // capture FSM
  // ---------------------------------------------------------
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      tcdm_pkg::amo_idle: begin
        if (load_i) begin
          state_d = tcdm_pkg::amo_commit;
        end
      end
      // commit lasts exactly one cycle
      tcdm_pkg::amo_commit: begin
        state_d = tcdm_pkg::amo_idle;
      end
      default: begin
        state_d = tcdm_pkg::amo_idle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= tcdm_pkg::amo_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // operands only matter in the commit cycle
  always_ff @(posedge clk_i) begin
    if (load_i) begin
      op_q      <= op_i;
      addr_q    <= addr_i;
      operand_q <= operand_i;
    end
  end

  // ---------------------------------------------------------
  // AMO ALU
  // ---------------------------------------------------------
  assign is_signed = (op_q == tcdm_pkg::amo_max) || (op_q == tcdm_pkg::amo_min);
  assign is_cmp    = is_signed || (op_q == tcdm_pkg::amo_maxu) ||
                     (op_q == tcdm_pkg::amo_minu);

  always_comb begin
    // sign extend for signed compares, zero extend otherwise
    adder_a   = {is_signed & bank_rdata_i[`TCDM_DATA_WIDTH-1], bank_rdata_i};
    adder_b   = {is_signed & operand_q[`TCDM_DATA_WIDTH-1], operand_q};
    adder_cin = 1'b0;
    // compare runs as old - operand
    if (is_cmp) begin
      adder_b   = ~adder_b;
      adder_cin = 1'b1;
    end
  end

  assign adder_sum = adder_a + adder_b + {{`TCDM_DATA_WIDTH{1'b0}}, adder_cin};
  // negative difference means old value below operand
  assign is_less   = adder_sum[`TCDM_DATA_WIDTH];

  always_comb begin
    // swap and anything unknown write the operand
    commit_wdata_o = operand_q;
    unique case (op_q)
      tcdm_pkg::amo_add: commit_wdata_o = adder_sum[`TCDM_DATA_WIDTH-1:0];
      tcdm_pkg::amo_and: commit_wdata_o = bank_rdata_i & operand_q;
      tcdm_pkg::amo_or:  commit_wdata_o = bank_rdata_i | operand_q;
      tcdm_pkg::amo_xor: commit_wdata_o = bank_rdata_i ^ operand_q;
      tcdm_pkg::amo_max,
      tcdm_pkg::amo_maxu: begin
        commit_wdata_o = is_less ? operand_q : bank_rdata_i;
      end
      tcdm_pkg::amo_min,
      tcdm_pkg::amo_minu: begin
        commit_wdata_o = is_less ? bank_rdata_i : operand_q;
      end
      default: commit_wdata_o = operand_q;
    endcase
  end

  assign commit_o      = (state_q == tcdm_pkg::amo_commit);
  assign commit_addr_o = addr_q;

endmodule

// ==== hw/tcdm_meta_buffer.sv ====
// Two-entry metadata store, filled on read acceptance and drained on response pop
`timescale 1ns/1ps

module tcdm_meta_buffer (
  input  logic            clk_i,
  input  logic            rst_ni,
  // metadata of the request being accepted
  input  tcdm_pkg::meta_t meta_in_i,
  resp_meta_if.buffer     meta
);

  tcdm_pkg::meta_t mem_q [2];

  // one pointer bit per direction, count tells full from empty
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] count_q;

  logic push_en;
  logic pop_en;

  // ---------------------------------------------------------
  // handshake
  // ---------------------------------------------------------
  assign push_en = meta.push && !meta.full;
  assign pop_en  = meta.pop && meta.valid;

  assign meta.full  = (count_q == 2'd2);
  assign meta.valid = (count_q != 2'd0);
  // oldest entry is always at the read pointer
  assign meta.meta  = mem_q[rd_ptr_q];

  // ---------------------------------------------------------
  // pointers and occupancy
  // ---------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push_en) begin
        wr_ptr_q <= !wr_ptr_q;
      end
      if (pop_en) begin
        rd_ptr_q <= !rd_ptr_q;
      end
      // simultaneous push and pop keeps the count
      if (push_en && !pop_en) begin
        count_q <= count_q + 2'd1;
      end else if (pop_en && !push_en) begin
        count_q <= count_q - 2'd1;
      end
    end
  end

  // entry storage
  always_ff @(posedge clk_i) begin
    if (push_en) begin
      mem_q[wr_ptr_q] <= meta_in_i;
    end
  end

endmodule

// ==== hw/tcdm_bank_port.sv ====
// Bank port muxing requests and AMO commits onto the SRAM and joining responses
`timescale 1ns/1ps
`include "tcdm_defines.svh"

module tcdm_bank_port (
  input  logic              clk_i,
  input  logic              rst_ni,
  // core side request
  input  logic              in_valid_i,
  input  logic              in_write_i,
  input  tcdm_pkg::amo_op_e in_amo_i,
  input  tcdm_pkg::addr_t   in_address_i,
  input  tcdm_pkg::data_t   in_wdata_i,
  input  tcdm_pkg::be_t     in_be_i,
  input  logic              in_ready_i,
  // AMO commit
  input  logic              commit_i,
  input  tcdm_pkg::addr_t   commit_addr_i,
  input  tcdm_pkg::data_t   commit_wdata_i,
  // bank read data, one cycle after the strobe
  input  tcdm_pkg::data_t   out_rdata_i,
  resp_meta_if.port         meta,
  // core side response
  output logic              in_ready_o,
  output logic              in_valid_o,
  output tcdm_pkg::data_t   in_rdata_o,
  // accepted AMO towards the AMO unit
  output logic              amo_load_o,
  output tcdm_pkg::amo_op_e amo_op_o,
  output tcdm_pkg::addr_t   amo_addr_o,
  output tcdm_pkg::data_t   amo_operand_o,
  // bank side
  output logic              out_req_o,
  output tcdm_pkg::addr_t   out_add_o,
  output logic              out_write_o,
  output tcdm_pkg::data_t   out_wdata_o,
  output tcdm_pkg::be_t     out_be_o
);

  logic            accept;
  logic            is_amo;
  logic            gnt_q;
  logic            pop_resp;
  logic            rdata_valid;
  logic            rdata_full_q;
  tcdm_pkg::data_t rdata_q;

  // ---------------------------------------------------------
  // request side
  // ---------------------------------------------------------
  // stall on commit, on a held response, or with no metadata slot left
  assign in_ready_o = !commit_i && !(in_valid_o && !in_ready_i) && !meta.full;
  assign accept     = in_valid_i && in_ready_o;
  assign is_amo     = (in_amo_i != tcdm_pkg::amo_none);

  // reads and AMOs both expect a response
  assign meta.push = accept && (is_amo || !in_write_i);

  assign amo_load_o    = accept && is_amo;
  assign amo_op_o      = in_amo_i;
  assign amo_addr_o    = in_address_i;
  assign amo_operand_o = in_wdata_i;

  always_comb begin
    // pass through by default, an AMO reads first
    out_req_o   = accept;
    out_add_o   = in_address_i;
    out_write_o = in_write_i && !is_amo;
    out_wdata_o = in_wdata_i;
    out_be_o    = in_be_i;
    // commit owns the bank for its cycle
    if (commit_i) begin
      out_req_o   = 1'b1;
      out_add_o   = commit_addr_i;
      out_write_o = 1'b1;
      out_wdata_o = commit_wdata_i;
      out_be_o    = {`TCDM_BE_WIDTH{1'b1}};
    end
  end

  // ---------------------------------------------------------
  // response side
  // ---------------------------------------------------------
  // read data arrives the cycle after a read strobe
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_q <= 1'b0;
    end else begin
      gnt_q <= out_req_o && !out_write_o;
    end
  end

  // fall-through register, holds the word only while it is not popped
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_full_q <= 1'b0;
    end else if (gnt_q && !pop_resp) begin
      rdata_full_q <= 1'b1;
    end else if (pop_resp) begin
      rdata_full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt_q && !pop_resp) begin
      rdata_q <= out_rdata_i;
    end
  end

  assign rdata_valid = gnt_q || rdata_full_q;
  assign in_rdata_o  = rdata_full_q ? rdata_q : out_rdata_i;

  // valid once data and metadata are both present
  assign in_valid_o = rdata_valid && meta.valid;
  assign pop_resp   = in_valid_o && in_ready_i;
  assign meta.pop   = pop_resp;

endmodule

// ==== hw/tcdm_adapter.sv ====
// TCDM adapter converting core valid/ready traffic into SRAM bank strobes with atomics
`timescale 1ns/1ps

module tcdm_adapter (
  input  logic              clk_i,
  input  logic              rst_ni,
  // core side request
  input  logic              in_valid_i,
  output logic              in_ready_o,
  input  tcdm_pkg::addr_t   in_address_i,
  input  tcdm_pkg::amo_op_e in_amo_i,
  input  logic              in_write_i,
  input  tcdm_pkg::data_t   in_wdata_i,
  input  tcdm_pkg::meta_t   in_meta_i,
  input  tcdm_pkg::be_t     in_be_i,
  // core side response
  output logic              in_valid_o,
  input  logic              in_ready_i,
  output tcdm_pkg::data_t   in_rdata_o,
  output tcdm_pkg::meta_t   in_meta_o,
  // bank side
  output logic              out_req_o,
  output tcdm_pkg::addr_t   out_add_o,
  output logic              out_write_o,
  output tcdm_pkg::data_t   out_wdata_o,
  output tcdm_pkg::be_t     out_be_o,
  input  tcdm_pkg::data_t   out_rdata_i
);

  // accepted AMO
  logic              amo_load;
  tcdm_pkg::amo_op_e amo_op;
  tcdm_pkg::addr_t   amo_addr;
  tcdm_pkg::data_t   amo_operand;

  // commit write
  logic              commit;
  tcdm_pkg::addr_t   commit_addr;
  tcdm_pkg::data_t   commit_wdata;

  resp_meta_if meta_if ();

  assign in_meta_o = meta_if.meta;

  // ---------------------------------------------------------
  // atomics and metadata, side by side
  // ---------------------------------------------------------
  tcdm_amo_unit i_amo_unit (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .load_i         (amo_load),
    .op_i           (amo_op),
    .addr_i         (amo_addr),
    .operand_i      (amo_operand),
    .bank_rdata_i   (out_rdata_i),
    .commit_o       (commit),
    .commit_addr_o  (commit_addr),
    .commit_wdata_o (commit_wdata)
  );

  tcdm_meta_buffer i_meta_buffer (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .meta_in_i (in_meta_i),
    .meta      (meta_if.buffer)
  );

  // ---------------------------------------------------------
  // bank access and response join
  // ---------------------------------------------------------
  tcdm_bank_port i_bank_port (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .in_valid_i     (in_valid_i),
    .in_write_i     (in_write_i),
    .in_amo_i       (in_amo_i),
    .in_address_i   (in_address_i),
    .in_wdata_i     (in_wdata_i),
    .in_be_i        (in_be_i),
    .in_ready_i     (in_ready_i),
    .commit_i       (commit),
    .commit_addr_i  (commit_addr),
    .commit_wdata_i (commit_wdata),
    .out_rdata_i    (out_rdata_i),
    .meta           (meta_if.port),
    .in_ready_o     (in_ready_o),
    .in_valid_o     (in_valid_o),
    .in_rdata_o     (in_rdata_o),
    .amo_load_o     (amo_load),
    .amo_op_o       (amo_op),
    .amo_addr_o     (amo_addr),
    .amo_operand_o  (amo_operand),
    .out_req_o      (out_req_o),
    .out_add_o      (out_add_o),
    .out_write_o    (out_write_o),
    .out_wdata_o    (out_wdata_o),
    .out_be_o       (out_be_o)
  );

endmodule

// ==== verif/tcdm_adapter_sva.sv ====
// Protocol assertions on the TCDM adapter ports, bound into the adapter
`timescale 1ns/1ps

module tcdm_adapter_sva (
  input logic              clk_i,
  input logic              rst_ni,
  input logic              in_valid_i,
  input logic              in_ready_o,
  input logic              in_write_i,
  input tcdm_pkg::amo_op_e in_amo_i,
  input logic              in_valid_o,
  input logic              in_ready_i,
  input tcdm_pkg::data_t   in_rdata_o,
  input tcdm_pkg::meta_t   in_meta_o,
  input logic              out_req_o,
  input logic              out_write_o,
  input tcdm_pkg::be_t     out_be_o
);

  logic accept;
  logic amo_accept;
  logic write_accept;
  logic resp_accept;
  logic req_seen_q;

  assign accept       = in_valid_i && in_ready_o;
  assign amo_accept   = accept && (in_amo_i != tcdm_pkg::amo_none);
  assign write_accept = accept && in_write_i && !amo_accept;
  // reads and AMOs both return a response
  assign resp_accept  = accept && !write_accept;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_seen_q <= 1'b0;
    end else if (in_valid_i) begin
      req_seen_q <= 1'b1;
    end
  end

  // ------------------------------------------------------------
  // request and response timing
  // ------------------------------------------------------------
  quiet_after_reset: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(req_seen_q || in_valid_i) |-> !in_valid_o && !out_req_o)
    else $error("response or bank strobe seen before the first request");

  resp_next_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_accept |=> in_valid_o)
    else $error("accepted read or AMO gave no response in the next cycle");

  write_strobe: assert property (@(posedge clk_i) disable iff (!rst_ni)
    write_accept |-> out_req_o && out_write_o ##1 !in_valid_o)
    else $error("write not strobed to the bank, or it produced a response");

  // AMO reads first, then commits with all bytes enabled
  amo_commit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    amo_accept |-> out_req_o && !out_write_o
      ##1 out_req_o && out_write_o && (out_be_o == '1) && !in_ready_o)
    else $error("AMO read or commit cycle has the wrong bank strobes or ready");

  // ------------------------------------------------------------
  // back-pressure
  // ------------------------------------------------------------
  hold_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    in_valid_o && !in_ready_i |-> !in_ready_o)
    else $error("request accepted while the response is held");

  hold_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    in_valid_o && !in_ready_i |=> in_valid_o && $stable(in_rdata_o) && $stable(in_meta_o))
    else $error("held response changed or dropped before it was taken");

endmodule

bind tcdm_adapter tcdm_adapter_sva i_sva (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .in_valid_i  (in_valid_i),
  .in_ready_o  (in_ready_o),
  .in_write_i  (in_write_i),
  .in_amo_i    (in_amo_i),
  .in_valid_o  (in_valid_o),
  .in_ready_i  (in_ready_i),
  .in_rdata_o  (in_rdata_o),
  .in_meta_o   (in_meta_o),
  .out_req_o   (out_req_o),
  .out_write_o (out_write_o),
  .out_be_o    (out_be_o)
);

// ==== verif/tb_tcdm_adapter.sv ====
// Testbench for the TCDM adapter with a bank model, random traffic and data checks
`timescale 1ns/1ps
`include "tcdm_defines.svh"

module tb_tcdm_adapter;

  // about 300 transactions of a few cycles each, plus reset
  localparam int MAX_CYCLES = 2000;

  logic              clk_i;
  logic              rst_ni;
  logic              in_valid_i;
  logic              in_ready_o;
  logic              in_write_i;
  logic              in_valid_o;
  logic              in_ready_i;
  logic              out_req_o;
  logic              out_write_o;
  tcdm_pkg::amo_op_e in_amo_i;
  tcdm_pkg::addr_t   in_address_i;
  tcdm_pkg::addr_t   out_add_o;
  tcdm_pkg::data_t   in_wdata_i;
  tcdm_pkg::data_t   in_rdata_o;
  tcdm_pkg::data_t   out_wdata_o;
  tcdm_pkg::data_t   out_rdata_i;
  tcdm_pkg::meta_t   in_meta_i;
  tcdm_pkg::meta_t   in_meta_o;
  tcdm_pkg::be_t     in_be_i;
  tcdm_pkg::be_t     out_be_o;

  // bank storage and the expected state next to it
  tcdm_pkg::data_t bank_mem [64];
  tcdm_pkg::data_t shadow_mem [64];
  tcdm_pkg::data_t exp_rdata;
  tcdm_pkg::meta_t exp_meta;
  tcdm_pkg::data_t exp_amo_wdata;
  tcdm_pkg::addr_t exp_amo_addr;

  logic        accept;
  logic        amo_accept;
  logic [31:0] ready_rnd;
  int          resp_errors;
  int          bank_errors;
  int          cycles;

  assign accept     = in_valid_i && in_ready_o;
  assign amo_accept = accept && (in_amo_i != tcdm_pkg::amo_none);

  tcdm_adapter uut (.*);

  // ------------------------------------------------------------
  // reference rules
  // ------------------------------------------------------------
  function automatic tcdm_pkg::data_t fill_word(input logic [5:0] idx);
    return ({26'd0, idx} * 32'h9e37_79b9) ^ 32'h5a5a_0000;
  endfunction

  function automatic tcdm_pkg::data_t merge_bytes(input tcdm_pkg::data_t old_v,
                                                  input tcdm_pkg::data_t new_v,
                                                  input tcdm_pkg::be_t be);
    tcdm_pkg::data_t res;
    res = old_v;
    for (int b = 0; b < `TCDM_BE_WIDTH; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_v[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic tcdm_pkg::data_t amo_result(input tcdm_pkg::amo_op_e op,
                                                 input tcdm_pkg::data_t old_v,
                                                 input tcdm_pkg::data_t opnd);
    case (op)
      tcdm_pkg::amo_add:  return old_v + opnd;
      tcdm_pkg::amo_and:  return old_v & opnd;
      tcdm_pkg::amo_or:   return old_v | opnd;
      tcdm_pkg::amo_xor:  return old_v ^ opnd;
      tcdm_pkg::amo_max:  return ($signed(old_v) > $signed(opnd)) ? old_v : opnd;
      tcdm_pkg::amo_maxu: return (old_v > opnd) ? old_v : opnd;
      tcdm_pkg::amo_min:  return ($signed(old_v) < $signed(opnd)) ? old_v : opnd;
      tcdm_pkg::amo_minu: return (old_v < opnd) ? old_v : opnd;
      // swap
      default:            return opnd;
    endcase
  endfunction

  // ------------------------------------------------------------
  // clock, bank model, shadow model
  // ------------------------------------------------------------
  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // read data shows up the cycle after a read strobe
  always @(posedge clk_i) begin
    if (out_req_o && out_write_o) begin
      bank_mem[out_add_o[5:0]] <= merge_bytes(bank_mem[out_add_o[5:0]], out_wdata_o, out_be_o);
    end else if (out_req_o) begin
      out_rdata_i <= bank_mem[out_add_o[5:0]];
    end
  end

  always @(posedge clk_i) begin
    if (amo_accept) begin
      shadow_mem[in_address_i[5:0]] <= amo_result(in_amo_i, shadow_mem[in_address_i[5:0]],
                                                  in_wdata_i);
      exp_amo_wdata <= amo_result(in_amo_i, shadow_mem[in_address_i[5:0]], in_wdata_i);
      exp_amo_addr  <= in_address_i;
      exp_rdata     <= shadow_mem[in_address_i[5:0]];
      exp_meta      <= in_meta_i;
    end else if (accept && in_write_i) begin
      shadow_mem[in_address_i[5:0]] <= merge_bytes(shadow_mem[in_address_i[5:0]], in_wdata_i,
                                                   in_be_i);
    end else if (accept) begin
      exp_rdata <= shadow_mem[in_address_i[5:0]];
      exp_meta  <= in_meta_i;
    end
  end

  // ------------------------------------------------------------
  // data checks
  // ------------------------------------------------------------
  rdata_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
    in_valid_o |-> in_rdata_o == exp_rdata)
    else begin
      resp_errors++;
      $display("error t=%0t in_rdata_o got %h expected %h", $time, $sampled(in_rdata_o),
               $sampled(exp_rdata));
    end

  meta_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
    in_valid_o |-> in_meta_o == exp_meta)
    else begin
      resp_errors++;
      $display("error t=%0t in_meta_o got %h expected %h", $time, $sampled(in_meta_o),
               $sampled(exp_meta));
    end

  // commit write follows the AMO by one cycle
  amo_wdata_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
    amo_accept |=> out_wdata_o == exp_amo_wdata)
    else begin
      bank_errors++;
      $display("error t=%0t out_wdata_o got %h expected %h", $time, $sampled(out_wdata_o),
               $sampled(exp_amo_wdata));
    end

  amo_addr_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
    amo_accept |=> out_add_o == exp_amo_addr)
    else begin
      bank_errors++;
      $display("error t=%0t out_add_o got %h expected %h", $time, $sampled(out_add_o),
               $sampled(exp_amo_addr));
    end

  // ------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------
  // response ready drops about a quarter of the cycles
  always @(posedge clk_i) begin
    #2;
    ready_rnd  = $urandom;
    in_ready_i = (ready_rnd[1:0] != 2'b00);
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, the request traffic did not complete", cycles);
      $display("checks done: %0d response errors, %0d bank errors", resp_errors, bank_errors);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic issue_request(input logic wr, input tcdm_pkg::amo_op_e op,
                               input logic [5:0] idx, input tcdm_pkg::data_t wdata,
                               input tcdm_pkg::be_t be);
    logic [31:0] rnd;
    logic        done;
    rnd          = $urandom;
    in_valid_i   = 1'b1;
    in_write_i   = wr;
    in_amo_i     = op;
    in_address_i = {26'd0, idx};
    in_wdata_i   = wdata;
    in_be_i      = be;
    in_meta_i    = rnd[7:0];
    done         = 1'b0;
    // ready is sampled mid cycle, once it has settled
    while (!done) begin
      @(negedge clk_i);
      done = in_ready_o;
      @(posedge clk_i);
      #2;
    end
    in_valid_i = 1'b0;
  endtask

  initial begin
    logic [31:0] rnd;
    logic [3:0]  op_sel;
    rnd          = $urandom(83);
    rst_ni       = 1'b0;
    in_valid_i   = 1'b0;
    in_write_i   = 1'b0;
    in_amo_i     = tcdm_pkg::amo_none;
    in_address_i = '0;
    in_wdata_i   = '0;
    in_meta_i    = '0;
    in_be_i      = '0;
    in_ready_i   = 1'b1;
    out_rdata_i  = '0;
    for (int i = 0; i < 64; i++) begin
      bank_mem[i[5:0]]   = fill_word(i[5:0]);
      shadow_mem[i[5:0]] = fill_word(i[5:0]);
    end
    repeat (8) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    // a few quiet cycles before the first request
    repeat (3) @(posedge clk_i);
    #2;
    for (int n = 0; n < 100; n++) begin
      rnd = $urandom;
      // write, then read the same word back
      issue_request(1'b1, tcdm_pkg::amo_none, rnd[5:0], $urandom, rnd[9:6]);
      issue_request(1'b0, tcdm_pkg::amo_none, rnd[5:0], '0, '0);
      rnd    = $urandom;
      op_sel = rnd[7:4] % 4'd10;
      // opcode zero is a plain read
      issue_request(1'b0, tcdm_pkg::amo_op_e'(op_sel), rnd[13:8], $urandom, 4'hf);
      if (rnd[16]) begin
        @(posedge clk_i);
        #2;
      end
    end
    do begin
      @(negedge clk_i);
    end while (in_valid_o);
    @(posedge clk_i);
    #2;
    $display("checks done: %0d response errors, %0d bank errors", resp_errors, bank_errors);
    if (resp_errors + bank_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+hw
hw/tcdm_pkg.sv
hw/resp_meta_if.sv
hw/tcdm_amo_unit.sv
hw/tcdm_meta_buffer.sv
hw/tcdm_bank_port.sv
hw/tcdm_adapter.sv
verif/tcdm_adapter_sva.sv
verif/tb_tcdm_adapter.sv

// ==== run.sh ====
#!/bin/sh
# build and run the TCDM adapter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_tcdm_adapter

# the run passes only if the testbench printed its pass line
./obj_dir/Vtb_tcdm_adapter | tee /dev/stderr | grep -x "TEST OK" > /dev/null
echo "simulation passed"
